// File: Bender.yml
package:
  name: lane_hough

sources:
  - include_dirs:
      - include
    files:
      - logic/image_pkg.sv
      - logic/hough_pkg.sv
      - logic/pixel_fifo.sv
      - logic/edge_decoder.sv
      - logic/hough_voter.sv
      - logic/line_peak_picker.sv
      - logic/lane_hough_top.sv
  - target: test
    files:
      - dv/lane_hough_properties.sv
      - dv/lane_hough_tb.sv

// File: dv/lane_hough_properties.sv
// Lane finder port properties
`timescale 1ns/10ps

module lane_hough_properties import hough_pkg::*; (
    input logic         clock,
    input logic         rst_n,
    input logic         pixel_full,
    input logic         line_done,
    input line_result_t line_result
);

    int unsigned fail_count = 0;

    // Done is a single-cycle pulse
    done_single_pulse: assert property (
        @(posedge clock) disable iff (!rst_n) line_done |=> !line_done
    ) else begin
        fail_count++;
        $error("line_done stayed high for two cycles");
    end

    // Result only moves together with done
    result_held: assert property (
        @(posedge clock) disable iff (!rst_n) !line_done |-> $stable(line_result)
    ) else begin
        fail_count++;
        $error("line_result changed while line_done was low");
    end

    reset_outputs_low: assert property (
        @(posedge clock) !rst_n |-> (!line_done && !pixel_full)
    ) else begin
        fail_count++;
        $error("line_done or pixel_full high during reset");
    end

endmodule

// File: dv/lane_hough_tb.sv
// Lane finder testbench
`timescale 1ns/10ps

module lane_hough_tb import image_pkg::*; import hough_pkg::*; ();

    localparam int W             = DEFAULT_WIDTH;
    localparam int H             = DEFAULT_HEIGHT;
    localparam int NPIX          = W * H;
    localparam int VOTE_MAX      = (1 << ACC_WIDTH) - 1;
    localparam int FULL_TIMEOUT  = 2000;
    localparam int DONE_TIMEOUT  = NPIX * NUM_THETAS * 2 + 1000;
    localparam int RANDOM_FRAMES = 6;

    // Angles 0 to 157.5 degrees in 1/256 units
    localparam int COS_REF [NUM_THETAS] = '{256, 237, 181, 98, 0, -98, -181, -237};
    localparam int SIN_REF [NUM_THETAS] = '{0, 98, 181, 237, 256, 237, 181, 98};

    localparam rgb_pixel_t BRIGHT = '{8'd255, 8'd255, 8'd255};

    logic         clock;
    logic         rst_n;
    logic         pixel_wr_en;
    rgb_pixel_t   pixel_din;
    logic         pixel_full;
    logic         line_done;
    line_result_t line_result;

    rgb_pixel_t   frame [NPIX];
    line_result_t expected_q [$];
    int           checks;
    int           errors;
    bit           stalled;

    lane_hough_top #(
        .WIDTH          (W),
        .HEIGHT         (H),
        .EDGE_THRESHOLD (DEFAULT_EDGE_THRESHOLD),
        .FIFO_DEPTH     (8)
    ) lane_hough_top_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .pixel_wr_en (pixel_wr_en),
        .pixel_din   (pixel_din),
        .pixel_full  (pixel_full),
        .line_done   (line_done),
        .line_result (line_result)
    );

    bind lane_hough_top lane_hough_properties lane_hough_properties_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Software accumulator, first maximum in address order
    function automatic line_result_t model_line();
        int           acc [NUM_THETAS * RHO_BINS];
        int           gray;
        int           rho;
        int           addr;
        int           best;
        rgb_pixel_t   p;
        line_result_t res;
        foreach (acc[i]) acc[i] = 0;
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                p = frame[y * W + x];
                gray = (int'(p.r) + 2 * int'(p.g) + int'(p.b)) >> 2;
                if (gray >= DEFAULT_EDGE_THRESHOLD) begin
                    for (int t = 0; t < NUM_THETAS; t++) begin
                        rho  = (x * COS_REF[t] + y * SIN_REF[t]) >>> 8;
                        addr = t * RHO_BINS + rho + RHO_OFFSET;
                        if (acc[addr] < VOTE_MAX) acc[addr]++;
                    end
                end
            end
        end
        best = 0;
        foreach (acc[a]) begin
            if (acc[a] > acc[best]) best = a;
        end
        res.theta = theta_idx_t'(best / RHO_BINS);
        res.rho   = rho_t'(best % RHO_BINS - RHO_OFFSET);
        res.votes = 8'(acc[best]);
        return res;
    endfunction

    function automatic rgb_pixel_t rand_pixel(input bit bright);
        int base;
        base = bright ? 128 : 0;
        return '{8'(base + $urandom % 128), 8'(base + $urandom % 128), 8'(base + $urandom % 128)};
    endfunction

    task automatic fill_frame(input rgb_pixel_t color);
        foreach (frame[i]) frame[i] = color;
    endtask

    task automatic make_random_frame();
        int density;
        density = $urandom % 101;
        foreach (frame[i]) frame[i] = rand_pixel(($urandom % 100) < density);
    endtask

    // Raster order writes, optionally with idle gaps
    task automatic write_frame(input bit bursty);
        int waited;
        for (int i = 0; i < NPIX && !stalled; i++) begin
            @(negedge clock);
            pixel_wr_en = 1'b0;
            if (bursty && ($urandom % 3 == 0)) begin
                repeat ($urandom % 4) @(negedge clock);
            end
            waited = 0;
            while (pixel_full && waited < FULL_TIMEOUT) begin
                @(negedge clock);
                waited++;
            end
            if (pixel_full) begin
                stalled = 1'b1;
                $display("Timed out waiting for pixel_full to clear at pixel %0d", i);
            end else begin
                pixel_wr_en = 1'b1;
                pixel_din   = frame[i];
            end
        end
        @(negedge clock);
        pixel_wr_en = 1'b0;
    endtask

    task automatic wait_line_done(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!stalled && !seen && cycles < DONE_TIMEOUT) begin
            @(negedge clock);
            seen = line_done;
            cycles++;
        end
        if (!stalled && !seen) begin
            stalled = 1'b1;
            $display("Timed out after %0d cycles waiting for line_done", DONE_TIMEOUT);
        end
    endtask

    task automatic check_next_result();
        bit           seen;
        line_result_t exp;
        wait_line_done(seen);
        if (seen) begin
            exp = expected_q.pop_front();
            checks++;
            assert (line_result == exp) else begin
                errors++;
                $display("[FAIL] %0t: got theta %0d rho %0d votes %0d, expected %0d %0d %0d",
                         $time, line_result.theta, $signed(line_result.rho), line_result.votes,
                         exp.theta, $signed(exp.rho), exp.votes);
            end
        end
    endtask

    // Hand-derived result first, then the DUT against the model
    task automatic run_directed_frame(input int theta, input int rho, input int votes);
        line_result_t exp;
        exp = model_line();
        checks++;
        assert (exp.theta == theta && $signed(exp.rho) == rho && exp.votes == votes) else begin
            errors++;
            $display("[FAIL] %0t: model gives theta %0d rho %0d votes %0d, expected %0d %0d %0d",
                     $time, exp.theta, $signed(exp.rho), exp.votes, theta, rho, votes);
        end
        expected_q.push_back(exp);
        write_frame(1'b0);
        check_next_result();
    endtask

    initial begin
        void'($urandom(32'h29033299));
        rst_n       = 1'b0;
        pixel_wr_en = 1'b0;
        pixel_din   = '0;
        checks      = 0;
        errors      = 0;
        stalled     = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // No edges, address 0 wins with zero votes
        fill_frame('0);
        run_directed_frame(0, -RHO_OFFSET, 0);

        fill_frame('0);
        for (int y = 0; y < H; y++) frame[y * W + 5] = BRIGHT;
        run_directed_frame(0, 5, 16);

        fill_frame('0);
        for (int x = 0; x < W; x++) frame[9 * W + x] = BRIGHT;
        run_directed_frame(4, 9, 16);

        // Gray 127 everywhere, gray 128 on the diagonal
        fill_frame('{8'd130, 8'd127, 8'd125});
        for (int d = 0; d < W; d++) frame[d * W + d] = '{8'd129, 8'd128, 8'd127};
        run_directed_frame(6, 0, 16);

        // Next frame streams in while the previous one is still voting or scanning
        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            make_random_frame();
            expected_q.push_back(model_line());
            fork
                write_frame(1'b1);
                begin
                    if (f > 0) check_next_result();
                end
            join
        end
        check_next_result();

        $display("Checks %0d, errors %0d, property failures %0d, timeouts %0d",
                 checks, errors, lane_hough_top_i.lane_hough_properties_i.fail_count, stalled);
        if (errors == 0 && lane_hough_top_i.lane_hough_properties_i.fail_count == 0
            && !stalled) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: include/trig_table.svh
// Hough angle tables
`ifndef TRIG_TABLE_SVH
`define TRIG_TABLE_SVH

// Eight angles from 0 degrees in steps of 22.5 degrees
// Values are scaled by 256 and rounded to the nearest integer
localparam logic signed [9:0] COS_Q [0:7] = '{
    10'sd256,
    10'sd237,
    10'sd181,
    10'sd98,
    10'sd0,
    -10'sd98,
    -10'sd181,
    -10'sd237
};

// Sine stays non-negative over the half turn
localparam logic signed [9:0] SIN_Q [0:7] = '{
    10'sd0,  10'sd98,  10'sd181, 10'sd237,
    10'sd256, 10'sd237, 10'sd181, 10'sd98
};

`endif

// File: lane_hough_top.f
+incdir+include
logic/image_pkg.sv
logic/hough_pkg.sv
logic/pixel_fifo.sv
logic/edge_decoder.sv
logic/hough_voter.sv
logic/line_peak_picker.sv
logic/lane_hough_top.sv
dv/lane_hough_properties.sv
dv/lane_hough_tb.sv

// File: logic/edge_decoder.sv
// Gray threshold edge decoder
`timescale 1ns/10ps

module edge_decoder import image_pkg::*; #(
    parameter int WIDTH          = DEFAULT_WIDTH,
    parameter int HEIGHT         = DEFAULT_HEIGHT,
    parameter int EDGE_THRESHOLD = DEFAULT_EDGE_THRESHOLD
) (
    input  logic        clock,
    input  logic        rst_n,
    output logic        fifo_rd_en,
    input  logic        fifo_empty,
    input  rgb_pixel_t  fifo_dout,
    output edge_event_t event_data,
    output logic        event_empty,
    input  logic        event_rd_en
);

    logic [9:0] gray_sum;
    gray_t      gray;
    coord_t     x_cnt;
    coord_t     y_cnt;
    logic       x_last;
    logic       y_last;
    logic       evt_valid;

    // Weights 1:2:1, divided by four
    assign gray_sum = {2'b00, fifo_dout.r} + {1'b0, fifo_dout.g, 1'b0} + {2'b00, fifo_dout.b};
    assign gray     = gray_sum[9:2];

    assign x_last = (x_cnt == coord_t'(WIDTH - 1));
    assign y_last = (y_cnt == coord_t'(HEIGHT - 1));

    // Pop when the output slot is free or being drained this cycle
    assign fifo_rd_en  = !fifo_empty && (!evt_valid || event_rd_en);
    assign event_empty = !evt_valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt     <= '0;
            y_cnt     <= '0;
            evt_valid <= 1'b0;
        end else if (fifo_rd_en) begin
            evt_valid <= 1'b1;
            // Raster order, x fastest
            x_cnt <= x_last ? '0 : x_cnt + 1'b1;
            if (x_last) begin
                y_cnt <= y_last ? '0 : y_cnt + 1'b1;
            end
        end else if (event_rd_en) begin
            evt_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fifo_rd_en) begin
            event_data.is_edge <= (gray >= gray_t'(EDGE_THRESHOLD));
            event_data.last    <= x_last && y_last;
            event_data.x       <= x_cnt;
            event_data.y       <= y_cnt;
        end
    end

endmodule

// File: logic/hough_pkg.sv
// Hough accumulator types
package hough_pkg;

    localparam int NUM_THETAS = 8;

    typedef logic [2:0] theta_idx_t;

    // Quantised sine and cosine
    `include "trig_table.svh"

    // Rho bins cover -24 to 23 for the default image
    localparam int RHO_BINS   = 48;
    localparam int RHO_OFFSET = 24;
    localparam int RHO_BIN_W  = $clog2(RHO_BINS);

    // One entry per theta and rho bin
    localparam int ACC_DEPTH = NUM_THETAS * RHO_BINS;
    localparam int ACC_WIDTH = 8;

    typedef logic signed [7:0]     rho_t;
    typedef logic [RHO_BIN_W-1:0]  rho_bin_t;
    typedef logic [8:0]            acc_addr_t;

    // Strongest line of a frame, 19 bits
    typedef struct packed {
        theta_idx_t           theta;
        rho_t                 rho;
        logic [ACC_WIDTH-1:0] votes;
    } line_result_t;

endpackage

// File: logic/hough_voter.sv
// Hough vote accumulator
`timescale 1ns/10ps

module hough_voter import image_pkg::*; import hough_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  edge_event_t          event_data,
    input  logic                 event_empty,
    output logic                 event_rd_en,
    output logic                 frame_voted,
    input  logic                 acc_rd_en,
    input  acc_addr_t            acc_rd_addr,
    output logic [ACC_WIDTH-1:0] acc_rd_data,
    input  logic                 scan_done
);

    typedef enum logic [1:0] {
        IDLE,
        VOTE,
        WAIT_SCAN
    } voter_state_t;

    voter_state_t         state;
    theta_idx_t           theta;
    logic [ACC_WIDTH-1:0] acc_mem [ACC_DEPTH];

    logic               active;
    logic               vote_en;
    logic               last_theta;
    logic signed [19:0] rho_sum;
    logic signed [11:0] rho_floor;
    logic signed [11:0] rho_bin;
    acc_addr_t          vote_addr;

    // Events are held off while the peak picker owns the accumulator
    assign active     = (state != WAIT_SCAN) && !event_empty;
    assign vote_en    = active && event_data.is_edge;
    assign last_theta = (theta == theta_idx_t'(NUM_THETAS - 1));

    // Non-edge pixels drain at once, edge pixels after the last angle
    assign event_rd_en = active && (!event_data.is_edge || last_theta);

    // rho = (x*cos + y*sin) >> 8, floor division
    assign rho_sum   = $signed({1'b0, event_data.x}) * COS_Q[theta]
                     + $signed({1'b0, event_data.y}) * SIN_Q[theta];
    assign rho_floor = rho_sum[19:8];
    assign rho_bin   = rho_floor + 12'(RHO_OFFSET);
    assign vote_addr = acc_addr_t'(theta * RHO_BINS) + acc_addr_t'(rho_bin_t'(rho_bin));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            theta       <= '0;
            frame_voted <= 1'b0;
        end else begin
            frame_voted <= 1'b0;
            if (vote_en) begin
                theta <= theta + 3'd1;
            end
            case (state)
                IDLE: begin
                    if (vote_en) begin
                        state <= VOTE;
                    end
                end
                VOTE: begin
                    if (last_theta) begin
                        state <= IDLE;
                    end
                end
                WAIT_SCAN: begin
                    if (scan_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            // Final pixel of the frame hands over to the scan
            if (event_rd_en && event_data.last) begin
                state       <= WAIT_SCAN;
                frame_voted <= 1'b1;
            end
        end
    end

    // Voting and scanning never overlap, so one port serves both
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ACC_DEPTH; i++) begin
                acc_mem[i] <= '0;
            end
            acc_rd_data <= '0;
        end else if (acc_rd_en) begin
            acc_rd_data          <= acc_mem[acc_rd_addr];
            acc_mem[acc_rd_addr] <= '0;
        end else if (vote_en && (acc_mem[vote_addr] != '1)) begin
            // Saturate at full scale
            acc_mem[vote_addr] <= acc_mem[vote_addr] + 1'b1;
        end
    end

endmodule

// File: logic/image_pkg.sv
// Image stream types
package image_pkg;

    // Frame geometry defaults
    localparam int DEFAULT_WIDTH          = 16;
    localparam int DEFAULT_HEIGHT         = 16;
    localparam int DEFAULT_EDGE_THRESHOLD = 128;

    typedef logic [7:0] coord_t;
    typedef logic [7:0] gray_t;

    // Red in the top byte, same layout as the 24-bit image bus
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_pixel_t;

    // One classified pixel, 18 bits
    typedef struct packed {
        logic   is_edge;
        logic   last;
        coord_t x;
        coord_t y;
    } edge_event_t;

endpackage

// File: logic/lane_hough_top.sv
// Lane line finder top level
`timescale 1ns/10ps

module lane_hough_top import image_pkg::*; import hough_pkg::*; #(
    parameter int WIDTH          = DEFAULT_WIDTH,
    parameter int HEIGHT         = DEFAULT_HEIGHT,
    parameter int EDGE_THRESHOLD = DEFAULT_EDGE_THRESHOLD,
    parameter int FIFO_DEPTH     = 8
) (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         pixel_wr_en,
    input  rgb_pixel_t   pixel_din,
    output logic         pixel_full,
    output logic         line_done,
    output line_result_t line_result
);

    // FIFO to decoder
    logic       fifo_rd_en;
    logic       fifo_empty;
    rgb_pixel_t fifo_dout;

    // Decoder to voter
    edge_event_t event_data;
    logic        event_empty;
    logic        event_rd_en;

    // Voter and picker handoff
    logic                 frame_voted;
    logic                 acc_rd_en;
    acc_addr_t            acc_rd_addr;
    logic [ACC_WIDTH-1:0] acc_rd_data;
    logic                 scan_done;

    pixel_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) pixel_fifo_i (
        .clock (clock),
        .rst_n (rst_n),
        .wr_en (pixel_wr_en),
        .din   (pixel_din),
        .full  (pixel_full),
        .rd_en (fifo_rd_en),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    edge_decoder #(
        .WIDTH          (WIDTH),
        .HEIGHT         (HEIGHT),
        .EDGE_THRESHOLD (EDGE_THRESHOLD)
    ) edge_decoder_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .fifo_rd_en  (fifo_rd_en),
        .fifo_empty  (fifo_empty),
        .fifo_dout   (fifo_dout),
        .event_data  (event_data),
        .event_empty (event_empty),
        .event_rd_en (event_rd_en)
    );

    hough_voter hough_voter_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .event_data  (event_data),
        .event_empty (event_empty),
        .event_rd_en (event_rd_en),
        .frame_voted (frame_voted),
        .acc_rd_en   (acc_rd_en),
        .acc_rd_addr (acc_rd_addr),
        .acc_rd_data (acc_rd_data),
        .scan_done   (scan_done)
    );

    line_peak_picker line_peak_picker_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .frame_voted (frame_voted),
        .acc_rd_en   (acc_rd_en),
        .acc_rd_addr (acc_rd_addr),
        .acc_rd_data (acc_rd_data),
        .scan_done   (scan_done),
        .line_done   (line_done),
        .line_result (line_result)
    );

endmodule

// File: logic/line_peak_picker.sv
// Accumulator peak search
`timescale 1ns/10ps

module line_peak_picker import hough_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 frame_voted,
    output logic                 acc_rd_en,
    output acc_addr_t            acc_rd_addr,
    input  logic [ACC_WIDTH-1:0] acc_rd_data,
    output logic                 scan_done,
    output logic                 line_done,
    output line_result_t         line_result
);

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        REPORT
    } picker_state_t;

    picker_state_t        state;
    theta_idx_t           scan_theta;
    theta_idx_t           rd_theta;
    theta_idx_t           best_theta;
    theta_idx_t           cand_theta;
    rho_bin_t             scan_bin;
    rho_bin_t             rd_bin;
    rho_bin_t             best_bin;
    rho_bin_t             cand_bin;
    logic [ACC_WIDTH-1:0] best_votes;
    logic [ACC_WIDTH-1:0] cand_votes;
    logic                 rd_valid;
    logic                 scan_last;
    logic                 take_new;
    logic                 done_q;

    assign acc_rd_en   = (state == SCAN);
    assign acc_rd_addr = acc_addr_t'(scan_theta * RHO_BINS) + acc_addr_t'(scan_bin);
    assign scan_last   = (scan_theta == theta_idx_t'(NUM_THETAS - 1))
                      && (scan_bin == rho_bin_t'(RHO_BINS - 1));

    // Strictly greater keeps the first maximum in address order
    assign take_new   = rd_valid && (acc_rd_data > best_votes);
    assign cand_votes = take_new ? acc_rd_data : best_votes;
    assign cand_theta = take_new ? rd_theta : best_theta;
    assign cand_bin   = take_new ? rd_bin : best_bin;

    assign scan_done = done_q;
    assign line_done = done_q;

    // Coordinates of the read in flight
    always_ff @(posedge clock) begin
        rd_theta <= scan_theta;
        rd_bin   <= scan_bin;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            scan_theta  <= '0;
            scan_bin    <= '0;
            rd_valid    <= 1'b0;
            best_votes  <= '0;
            best_theta  <= '0;
            best_bin    <= '0;
            done_q      <= 1'b0;
            line_result <= '0;
        end else begin
            done_q     <= 1'b0;
            rd_valid   <= acc_rd_en;
            best_votes <= cand_votes;
            best_theta <= cand_theta;
            best_bin   <= cand_bin;
            case (state)
                IDLE: begin
                    if (frame_voted) begin
                        state      <= SCAN;
                        scan_theta <= '0;
                        scan_bin   <= '0;
                        best_votes <= '0;
                        best_theta <= '0;
                        best_bin   <= '0;
                    end
                end
                SCAN: begin
                    if (scan_bin == rho_bin_t'(RHO_BINS - 1)) begin
                        scan_bin   <= '0;
                        scan_theta <= scan_theta + 3'd1;
                    end else begin
                        scan_bin <= scan_bin + 1'b1;
                    end
                    if (scan_last) begin
                        state <= REPORT;
                    end
                end
                REPORT: begin
                    // Last read data is folded in here
                    state             <= IDLE;
                    done_q            <= 1'b1;
                    line_result.theta <= cand_theta;
                    line_result.rho   <= rho_t'(cand_bin) - rho_t'(RHO_OFFSET);
                    line_result.votes <= cand_votes;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: logic/pixel_fifo.sv
// Pixel input FIFO
`timescale 1ns/10ps

module pixel_fifo import image_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       wr_en,
    input  rgb_pixel_t din,
    output logic       full,
    input  logic       rd_en,
    output rgb_pixel_t dout,
    output logic       empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rgb_pixel_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Writes while full and reads while empty are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Show-ahead read port
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule
